// File: Bender.yml
package:
  name: mem_subsys

sources:
  - files:
      - rtl/mem_sys_pkg.sv
      - rtl/dual_port_ram.sv
      - rtl/load_store_unit.sv
      - rtl/mem_subsys_top.sv
  - target: test
    files:
      - test/clk_gen.sv
      - test/tb_mem_subsys.sv

// File: mem_subsys.f
rtl/mem_sys_pkg.sv
rtl/dual_port_ram.sv
rtl/load_store_unit.sv
rtl/mem_subsys_top.sv
test/clk_gen.sv
test/tb_mem_subsys.sv

// File: rtl/dual_port_ram.sv
////////////////////////////////////////////////////////////
// Byte-array RAM, read-only fetch port A and
// byte-enabled read/write data port B
////////////////////////////////////////////////////////////

module dual_port_ram
    import mem_sys_pkg::*;
(
    input  logic              clk,

    // Port A, instruction fetch
    input  logic              a_en_i,
    input  logic [ADDR_W-1:0] a_addr_i,
    output logic [XLEN-1:0]   a_rdata_o,

    // Port B, data access
    input  logic              b_en_i,
    input  logic [BE_W-1:0]   b_we_i,
    input  logic [ADDR_W-1:0] b_addr_i,
    input  logic [XLEN-1:0]   b_wdata_i,
    output logic [XLEN-1:0]   b_rdata_o
);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    // Contents start cleared so every run begins from a known image
    logic [7:0] mem [0:MEM_BYTES-1] = '{default: 8'h00};

    logic b_rd;   // Port B read strobe

    assign b_rd = b_en_i && (b_we_i == '0);   // Read only when no lane writes

    // Gathers BE_W bytes starting at addr, lowest address in lane 0
    function automatic logic [XLEN-1:0] read_word(input logic [ADDR_W-1:0] addr);
        logic [XLEN-1:0] word;
        word = '0;
        for (int i = 0; i < BE_W; i++) begin
            word[8*i +: 8] = mem[addr + ADDR_W'(i)];
        end
        return word;
    endfunction

    ////////////////////////////////////////////////////////////
    // Port B write
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (b_en_i) begin
            for (int i = 0; i < BE_W; i++) begin
                if (b_we_i[i]) begin
                    mem[b_addr_i + ADDR_W'(i)] <= b_wdata_i[8*i +: 8];  // One lane per enable
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered reads
    ////////////////////////////////////////////////////////////

    // Port A sees the array before this edge's write, so a fetch
    // colliding with a store returns the old word
    always_ff @(posedge clk) begin
        if (a_en_i) begin
            a_rdata_o <= read_word(a_addr_i);   // Holds while disabled
        end
    end

    always_ff @(posedge clk) begin
        if (b_rd) begin
            b_rdata_o <= read_word(b_addr_i);   // Little-endian word
        end
    end

endmodule

// File: rtl/load_store_unit.sv
////////////////////////////////////////////////////////////
// Load/store unit: lane alignment, byte enables, alignment
// check and load result formatting
////////////////////////////////////////////////////////////

module load_store_unit
    import mem_sys_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,

    // Core side
    input  logic              req_i,
    input  mem_op_e           op_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [XLEN-1:0]   wdata_i,
    output logic [XLEN-1:0]   rdata_o,
    output logic              rvalid_o,
    output logic              misaligned_o,

    // RAM side
    output logic              ram_en_o,
    output logic [BE_W-1:0]   ram_we_o,
    output logic [ADDR_W-1:0] ram_addr_o,
    output logic [XLEN-1:0]   ram_wdata_o,
    input  logic [XLEN-1:0]   ram_rdata_i
);

    ////////////////////////////////////////////////////////////
    // Request decode
    ////////////////////////////////////////////////////////////

    logic            is_load;
    logic            is_store;
    logic [1:0]      size;        // 0 byte, 1 half, 2 word
    logic [1:0]      align_mask;  // Address bits that must be zero
    logic [BE_W-1:0] be_mask;     // Enables before the lane shift
    logic            misaligned;
    logic            access_ok;
    logic            load_ok;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        size     = 2'd0;
        case (op_i)
            MEM_LB, MEM_LBU: begin
                is_load = 1'b1;
            end
            MEM_LH, MEM_LHU: begin
                is_load = 1'b1;
                size    = 2'd1;
            end
            MEM_LW: begin
                is_load = 1'b1;
                size    = 2'd2;
            end
            MEM_SB: begin
                is_store = 1'b1;
            end
            MEM_SH: begin
                is_store = 1'b1;
                size     = 2'd1;
            end
            MEM_SW: begin
                is_store = 1'b1;
                size     = 2'd2;
            end
            default: ;                           // MEM_NONE and unused codes
        endcase
    end

    always_comb begin
        case (size)
            2'd1:    {align_mask, be_mask} = {2'b01, 4'b0011};
            2'd2:    {align_mask, be_mask} = {2'b11, 4'b1111};
            default: {align_mask, be_mask} = {2'b00, 4'b0001};
        endcase
    end

    assign misaligned = req_i && (is_load || is_store) && |(addr_i[1:0] & align_mask);
    assign access_ok  = req_i && (is_load || is_store) && !misaligned;
    assign load_ok    = access_ok && is_load;

    ////////////////////////////////////////////////////////////
    // RAM drive
    ////////////////////////////////////////////////////////////

    assign ram_en_o   = access_ok;                       // Misaligned ops never reach RAM
    assign ram_we_o   = (access_ok && is_store) ? (be_mask << addr_i[1:0]) : '0;
    assign ram_addr_o = {addr_i[ADDR_W-1:2], 2'b00};     // Word-aligned

    always_comb begin
        case (size)
            2'd0:    ram_wdata_o = {4{wdata_i[7:0]}};    // Byte in every lane
            2'd1:    ram_wdata_o = {2{wdata_i[15:0]}};   // Half in both halves
            default: ram_wdata_o = wdata_i;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Response stage
    ////////////////////////////////////////////////////////////

    logic       rvalid_q;
    logic       misaligned_q;
    mem_op_e    op_q;
    logic [1:0] offset_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rvalid_q     <= 1'b0;
            misaligned_q <= 1'b0;
        end else begin
            rvalid_q     <= load_ok;     // One-cycle pulse per load
            misaligned_q <= misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (load_ok) begin
            op_q     <= op_i;
            offset_q <= addr_i[1:0];
        end
    end

    logic [XLEN-1:0] lane;

    assign lane = ram_rdata_i >> {offset_q, 3'b000};     // Addressed lane to bit 0

    always_comb begin
        case (op_q)
            MEM_LB:  rdata_o = {{(XLEN-8){lane[7]}}, lane[7:0]};
            MEM_LBU: rdata_o = {{(XLEN-8){1'b0}}, lane[7:0]};
            MEM_LH:  rdata_o = {{(XLEN-16){lane[15]}}, lane[15:0]};
            MEM_LHU: rdata_o = {{(XLEN-16){1'b0}}, lane[15:0]};
            default: rdata_o = ram_rdata_i;              // Word load
        endcase
    end

    assign rvalid_o     = rvalid_q;
    assign misaligned_o = misaligned_q;

endmodule

// File: rtl/mem_subsys_top.sv
////////////////////////////////////////////////////////////
// Memory subsystem top: load/store unit and dual-port RAM
////////////////////////////////////////////////////////////

module mem_subsys_top
    import mem_sys_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,

    // Instruction fetch port
    input  logic              fetch_en_i,
    input  logic [ADDR_W-1:0] fetch_addr_i,
    output logic [XLEN-1:0]   fetch_data_o,

    // Core data port
    input  logic              data_req_i,
    input  mem_op_e           data_op_i,
    input  logic [ADDR_W-1:0] data_addr_i,
    input  logic [XLEN-1:0]   data_wdata_i,
    output logic [XLEN-1:0]   data_rdata_o,
    output logic              data_rvalid_o,
    output logic              data_misaligned_o
);

    logic              b_en;
    logic [BE_W-1:0]   b_we;
    logic [ADDR_W-1:0] b_addr;
    logic [XLEN-1:0]   b_wdata;
    logic [XLEN-1:0]   b_rdata;

    load_store_unit i_load_store_unit (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (data_req_i),
        .op_i         (data_op_i),
        .addr_i       (data_addr_i),
        .wdata_i      (data_wdata_i),
        .rdata_o      (data_rdata_o),
        .rvalid_o     (data_rvalid_o),
        .misaligned_o (data_misaligned_o),
        .ram_en_o     (b_en),
        .ram_we_o     (b_we),
        .ram_addr_o   (b_addr),
        .ram_wdata_o  (b_wdata),
        .ram_rdata_i  (b_rdata)
    );

    dual_port_ram i_dual_port_ram (
        .clk       (clk),
        .a_en_i    (fetch_en_i),
        .a_addr_i  ({fetch_addr_i[ADDR_W-1:2], 2'b00}),  // Fetch is word-aligned
        .a_rdata_o (fetch_data_o),
        .b_en_i    (b_en),
        .b_we_i    (b_we),
        .b_addr_i  (b_addr),
        .b_wdata_i (b_wdata),
        .b_rdata_o (b_rdata)
    );

endmodule

// File: rtl/mem_sys_pkg.sv
////////////////////////////////////////////////////////////
// Memory subsystem sizes, widths and memory operation codes
////////////////////////////////////////////////////////////

package mem_sys_pkg;

    ////////////////////////////////////////////////////////////
    // Memory geometry
    ////////////////////////////////////////////////////////////

    localparam int MEM_BYTES = 4096;               // RAM size in bytes
    localparam int ADDR_W    = $clog2(MEM_BYTES);  // Byte address width
    localparam int XLEN      = 32;                 // Data word width
    localparam int BE_W      = XLEN / 8;           // Byte lanes per word

    ////////////////////////////////////////////////////////////
    // Memory operations
    ////////////////////////////////////////////////////////////

    // Loads come first, then stores. Codes above MEM_SW are unused
    // and are treated like MEM_NONE by the load/store unit.
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,   // No access
        MEM_LB   = 4'd1,   // Load byte, sign-extended
        MEM_LH   = 4'd2,   // Load half, sign-extended
        MEM_LW   = 4'd3,   // Load word
        MEM_LBU  = 4'd4,   // Load byte, zero-extended
        MEM_LHU  = 4'd5,   // Load half, zero-extended
        MEM_SB   = 4'd6,   // Store byte
        MEM_SH   = 4'd7,   // Store half
        MEM_SW   = 4'd8    // Store word
    } mem_op_e;

endpackage

// File: test/clk_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock (10 ns period) and power-on reset
////////////////////////////////////////////////////////////

module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;           // 10 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);        // Reset held for 16 cycles
        #1 rst_n_o = 1'b1;
    end

endmodule

// File: test/tb_input.txt
# port (D data, F fetch, B fetch and data op at one address)  op  addr  wdata
# expected data or fetch word (none for no data check)  misaligned flag
D LW   100 00000000 00000000 0
D SW   100 12345678 none     0
D LW   100 00000000 12345678 0
D LB   100 00000000 00000078 0
D LH   102 00000000 00001234 0
D SB   200 ffffffa1 none     0
D SB   201 555555b2 none     0
D SB   202 000000c3 none     0
D SB   203 abcdefd4 none     0
D LW   200 00000000 d4c3b2a1 0
D SW   300 c3a596f1 none     0
D LB   300 00000000 fffffff1 0
D LB   301 00000000 ffffff96 0
D LB   302 00000000 ffffffa5 0
D LB   303 00000000 ffffffc3 0
D LBU  300 00000000 000000f1 0
D LBU  301 00000000 00000096 0
D LBU  302 00000000 000000a5 0
D LBU  303 00000000 000000c3 0
D LH   300 00000000 ffff96f1 0
D LH   302 00000000 ffffc3a5 0
D LHU  300 00000000 000096f1 0
D LHU  302 00000000 0000c3a5 0
D SH   306 1234beef none     0
D LW   304 00000000 beef0000 0
D LH   301 00000000 none     1
D LW   302 00000000 none     1
D SW   102 deadbeef none     1
D SH   103 0000ffff none     1
D LW   100 00000000 12345678 0
D LW   300 00000000 c3a596f1 0
F NONE 100 00000000 12345678 0
F NONE 202 00000000 d4c3b2a1 0
B SW   100 cafef00d 12345678 0
F NONE 100 00000000 cafef00d 0
D LW   100 00000000 cafef00d 0
D SB   305 00000011 none     0
D LW   304 00000000 beef1100 0

// File: test/tb_mem_subsys.sv
////////////////////////////////////////////////////////////
// Memory subsystem testbench with vector-file stimulus,
// response checking and watchdog
////////////////////////////////////////////////////////////

module tb_mem_subsys
    import mem_sys_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic              clk;
    logic              rst_n;
    logic              fetch_en;
    logic [ADDR_W-1:0] fetch_addr;
    logic [XLEN-1:0]   fetch_data;
    logic              data_req;
    mem_op_e           data_op;
    logic [ADDR_W-1:0] data_addr;
    logic [XLEN-1:0]   data_wdata;
    logic [XLEN-1:0]   data_rdata;
    logic              data_rvalid;
    logic              data_mis;

    // Vectors as read from the file
    byte               vec_port[$];
    mem_op_e           vec_op[$];
    bit                vec_load[$];
    logic [ADDR_W-1:0] vec_addr[$];
    logic [XLEN-1:0]   vec_wdata[$];
    logic [XLEN-1:0]   vec_exp[$];
    bit                vec_mis[$];

    // Outstanding responses in request order
    logic [XLEN-1:0]   rsp_value[$];
    bit                rsp_mis[$];
    int unsigned       rsp_cycle[$];
    int                rsp_index[$];
    logic [XLEN-1:0]   ftc_value[$];
    int unsigned       ftc_cycle[$];
    int                ftc_index[$];

    int unsigned       cycle_cnt = 0;
    int                num_vec = 0;
    bit                vectors_loaded = 1'b0;

    clk_gen i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mem_subsys_top i_mem_subsys_top (
        .clk               (clk),
        .rst_n_i           (rst_n),
        .fetch_en_i        (fetch_en),
        .fetch_addr_i      (fetch_addr),
        .fetch_data_o      (fetch_data),
        .data_req_i        (data_req),
        .data_op_i         (data_op),
        .data_addr_i       (data_addr),
        .data_wdata_i      (data_wdata),
        .data_rdata_o      (data_rdata),
        .data_rvalid_o     (data_rvalid),
        .data_misaligned_o (data_mis)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error: time %0d ns, %s expected 0x%h, got 0x%h",
                                        $time, name, expected, actual));
        end
    endtask

    function automatic int op_code(input string name);
        case (name)
            "NONE":  return MEM_NONE;
            "LB":    return MEM_LB;
            "LH":    return MEM_LH;
            "LW":    return MEM_LW;
            "LBU":   return MEM_LBU;
            "LHU":   return MEM_LHU;
            "SB":    return MEM_SB;
            "SH":    return MEM_SH;
            "SW":    return MEM_SW;
            default: return -1;
        endcase
    endfunction

    task automatic apply_vector(input int idx);
        fetch_en = 1'b0;
        data_req = 1'b0;
        data_op  = MEM_NONE;
        if (vec_port[idx] != "F" && vec_op[idx] != MEM_NONE) begin
            data_req   = 1'b1;
            data_op    = vec_op[idx];
            data_addr  = vec_addr[idx];
            data_wdata = vec_wdata[idx];
            if (vec_load[idx] || vec_mis[idx]) begin      // Stores give no response
                rsp_value.push_back(vec_exp[idx]);
                rsp_mis.push_back(vec_mis[idx]);
                rsp_cycle.push_back(cycle_cnt + 1);
                rsp_index.push_back(idx);
            end
        end
        if (vec_port[idx] != "D") begin
            fetch_en   = 1'b1;
            fetch_addr = vec_addr[idx];
            ftc_value.push_back(vec_exp[idx]);
            ftc_cycle.push_back(cycle_cnt + 1);
            ftc_index.push_back(idx);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin : stimulus
        int                fd;
        int                fields;
        int                code;
        int                ch;
        int                mis_v;
        string             port_s;
        string             op_s;
        string             exp_s;
        logic [ADDR_W-1:0] addr_v;
        logic [XLEN-1:0]   wdata_v;
        logic [XLEN-1:0]   exp_v;
        fetch_en   = 1'b0;
        fetch_addr = '0;
        data_req   = 1'b0;
        data_op    = MEM_NONE;
        data_addr  = '0;
        data_wdata = '0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("data_rvalid_o after reset", '0, data_rvalid);
        check_value("data_misaligned_o after reset", '0, data_mis);

        fd = $fopen("test/tb_input.txt", "r");
        if (fd == 0) stop_with_failure("the vector file test/tb_input.txt could not be opened");
        while ($fscanf(fd, "%s", port_s) == 1) begin
            if (port_s.getc(0) == "#") begin
                ch = $fgetc(fd);                      // Skip the rest of a comment line
                while (ch != 10 && ch != -1) ch = $fgetc(fd);
            end else begin
                fields = $fscanf(fd, "%s %h %h %s %d", op_s, addr_v, wdata_v, exp_s, mis_v);
                code   = op_code(op_s);
                if (fields != 5 || code < 0) begin
                    stop_with_failure($sformatf("vector %0d in the vector file is malformed",
                                                vec_op.size()));
                end
                exp_v = '0;
                if (exp_s != "none") void'($sscanf(exp_s, "%h", exp_v));
                vec_port.push_back(port_s.getc(0));
                vec_op.push_back(mem_op_e'(code));
                vec_load.push_back(op_s.getc(0) == "L");
                vec_addr.push_back(addr_v);
                vec_wdata.push_back(wdata_v);
                vec_exp.push_back(exp_v);
                vec_mis.push_back(mis_v != 0);
            end
        end
        $fclose(fd);
        num_vec = vec_op.size();
        if (num_vec == 0) stop_with_failure("the vector file holds no vectors");
        vectors_loaded = 1'b1;

        for (int i = 0; i < num_vec; i++) begin
            @(posedge clk);
            #1;
            apply_vector(i);                          // One request per cycle
        end
        @(posedge clk);
        #1;
        fetch_en = 1'b0;
        data_req = 1'b0;
        data_op  = MEM_NONE;
        repeat (3) @(negedge clk);                    // Last response is one cycle out
        if (rsp_value.size() != 0 || ftc_value.size() != 0) begin
            stop_with_failure($sformatf("%0d data and %0d fetch responses never arrived",
                                        rsp_value.size(), ftc_value.size()));
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Response checking at the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin : response_monitor
        logic [XLEN-1:0] exp_val;
        bit              exp_mis;
        int unsigned     exp_cyc;
        int              idx;
        if (rst_n === 1'b1) begin
            if (data_rvalid !== 1'b0 || data_mis !== 1'b0) begin
                if (rsp_value.size() == 0) begin
                    stop_with_failure("a data response arrived with no request outstanding");
                end else begin
                    exp_val = rsp_value.pop_front();
                    exp_mis = rsp_mis.pop_front();
                    exp_cyc = rsp_cycle.pop_front();
                    idx     = rsp_index.pop_front();
                    check_value($sformatf("response cycle (vector %0d)", idx),
                                exp_cyc, cycle_cnt);
                    check_value($sformatf("data_misaligned_o (vector %0d)", idx),
                                exp_mis, data_mis);
                    check_value($sformatf("data_rvalid_o (vector %0d)", idx),
                                !exp_mis, data_rvalid);
                    if (!exp_mis) begin
                        check_value($sformatf("data_rdata_o (vector %0d)", idx),
                                    exp_val, data_rdata);
                    end
                end
            end else if (rsp_cycle.size() != 0 && rsp_cycle[0] <= cycle_cnt) begin
                stop_with_failure($sformatf("no data response for vector %0d in its cycle",
                                            rsp_index[0]));
            end
            if (ftc_cycle.size() != 0 && ftc_cycle[0] == cycle_cnt) begin
                exp_val = ftc_value.pop_front();
                void'(ftc_cycle.pop_front());
                idx     = ftc_index.pop_front();
                check_value($sformatf("fetch_data_o (vector %0d)", idx), exp_val, fetch_data);
            end
        end
    end

    initial begin : watchdog
        wait (vectors_loaded);
        #((num_vec + 40) * 10);                       // Vector cycles plus slack
        stop_with_failure("timeout: the run did not finish in the expected time");
    end

endmodule
